//--- axi_bus_pkg.sv
`include "cache_axi_consts.svh"

package axi_bus_pkg;

    typedef enum logic [1:0] {
        axi_burst_fixed = 2'b00,
        axi_burst_incr  = 2'b01,
        axi_burst_wrap  = 2'b10
    } axi_burst_e;

    // address payload, also used for the aw channel
    typedef struct packed {
        logic [`CA_AXI_ID_W-1:0]    id;
        logic [`CA_ADDR_W-1:0]      addr;
        logic [7:0]                 len;    // beats - 1
        logic [2:0]                 size;   // log2 bytes per beat
        axi_burst_e                 burst;
    } axi_ar_t;

    typedef struct packed {
        logic [`CA_AXI_ID_W-1:0]    id;     // axi3 keeps wid
        logic [`CA_BEAT_W-1:0]      data;
        logic [`CA_BEAT_W/8-1:0]    strb;
        logic                       last;
    } axi_w_t;

    typedef struct packed {
        logic [`CA_AXI_ID_W-1:0]    id;
        logic [`CA_BEAT_W-1:0]      data;
        logic [1:0]                 resp;
        logic                       last;
    } axi_r_t;

    typedef struct packed {
        logic [`CA_AXI_ID_W-1:0]    id;
        logic [1:0]                 resp;
    } axi_b_t;

endpackage

//--- axi_chan_slice.sv
`timescale 1ns/1ps
`include "cache_axi_consts.svh"

module axi_chan_slice #(
    parameter type payload_t = logic
) (
    input  logic        clk,
    input  logic        rst_n,
    input  payload_t    in_data,
    input  logic        in_valid,
    output logic        in_ready,
    output payload_t    out_data,
    output logic        out_valid,
    input  logic        out_ready
);

    logic in_fire;

    // take new data when empty or when the held word leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_data <= in_data;
        end
    end

    // axi rule on the outgoing side
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("slice output changed under back-pressure");

endmodule

//--- burst_issuer.sv
`timescale 1ns/1ps
`include "cache_axi_consts.svh"

module burst_issuer (
    input  logic                        clk,
    input  logic                        rst_n,
    // command from the arbiter
    input  cache_req_pkg::bus_cmd_t     cmd,
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    // address channels, through the slices
    output axi_bus_pkg::axi_ar_t        ar_in,
    output logic                        ar_in_valid,
    input  logic                        ar_in_ready,
    output axi_bus_pkg::axi_ar_t        aw_in,
    output logic                        aw_in_valid,
    input  logic                        aw_in_ready,
    // write data
    output axi_bus_pkg::axi_w_t         w,
    output logic                        wvalid,
    input  logic                        wready,
    // read data
    input  axi_bus_pkg::axi_r_t         r,
    input  logic                        rvalid,
    output logic                        rready,
    // write response
    input  axi_bus_pkg::axi_b_t         b,
    input  logic                        bvalid,
    output logic                        bready,
    // beats back to the caches
    output cache_req_pkg::cache_ret_t   inst_ret,
    output cache_req_pkg::cache_ret_t   data_ret
);

    import cache_req_pkg::*;
    import axi_bus_pkg::*;

    localparam int CNT_W = $clog2(`CA_BURST_BEATS);

    typedef enum logic {
        st_idle,
        st_busy
    } state_e;

    state_e                     state;
    bus_cmd_t                   cur_cmd;
    logic                       addr_sent;   // ar or aw handshake done
    logic                       wdata_sent;  // last w beat accepted
    logic [CNT_W-1:0]           beat_cnt;
    logic [`CA_AXI_ID_W-1:0]    txn_id;
    axi_ar_t                    addr_pay;
    cache_src_e                 r_src;
    logic                       cmd_take;
    logic                       addr_fire;
    logic                       w_fire;
    logic                       txn_done;

    // only one burst outstanding, so responses are always taken
    assign rready = 1'b1;
    assign bready = 1'b1;

    assign cmd_ready = (state == st_idle);
    assign cmd_take  = cmd_valid && cmd_ready;

    assign addr_fire = (ar_in_valid && ar_in_ready) || (aw_in_valid && aw_in_ready);
    assign w_fire    = wvalid && wready;
    assign txn_done  = (state == st_busy) &&
                       ((rvalid && rready && r.last) || (bvalid && bready));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            addr_sent  <= 1'b0;
            wdata_sent <= 1'b0;
            beat_cnt   <= '0;
        end else if (cmd_take) begin
            state      <= st_busy;
            addr_sent  <= 1'b0;
            wdata_sent <= 1'b0;
            beat_cnt   <= '0;
        end else begin
            if (txn_done) begin
                state <= st_idle;
            end
            if (addr_fire) begin
                addr_sent <= 1'b1;
            end
            if (w_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (w.last) begin
                    wdata_sent <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_take) begin
            cur_cmd <= cmd;
        end
    end

    assign txn_id = {{(`CA_AXI_ID_W-1){1'b0}}, cur_cmd.src};

    // same address payload for ar and aw, only the valid differs
    assign addr_pay.id    = txn_id;
    assign addr_pay.addr  = {cur_cmd.addr[`CA_ADDR_W-1:2], 2'b00}; // word aligned
    assign addr_pay.len   = 8'(`CA_BURST_BEATS - 1);
    assign addr_pay.size  = 3'($clog2(`CA_BEAT_W / 8));
    assign addr_pay.burst = axi_burst_incr;

    assign ar_in       = addr_pay;
    assign aw_in       = addr_pay;
    assign ar_in_valid = (state == st_busy) && !cur_cmd.wr && !addr_sent;
    assign aw_in_valid = (state == st_busy) &&  cur_cmd.wr && !addr_sent;

    // write beats go out without waiting for aw
    assign w.id   = txn_id;
    assign w.data = cur_cmd.line[beat_cnt*`CA_BEAT_W +: `CA_BEAT_W];
    assign w.strb = cur_cmd.wstrb;
    assign w.last = (beat_cnt == CNT_W'(`CA_BURST_BEATS - 1));
    assign wvalid = (state == st_busy) && cur_cmd.wr && !wdata_sent;

    // steer read beats by rid
    assign r_src = cache_src_e'(r.id[0]);

    assign inst_ret.valid = rvalid && (r_src == src_icache);
    assign inst_ret.last  = r.last;
    assign inst_ret.data  = r.data;
    assign data_ret.valid = rvalid && (r_src == src_dcache);
    assign data_ret.last  = r.last;
    assign data_ret.data  = r.data;

    a_wvalid_write: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("w beat dropped or changed while stalled");

    a_wvalid_busy: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid |-> state == st_busy && cur_cmd.wr)
        else $error("wvalid outside a write burst");

    // slave may only answer after our address went out, with our id
    a_rvalid_read: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid |-> state == st_busy && !cur_cmd.wr && addr_sent && r.id == txn_id)
        else $error("read beat outside the outstanding read burst");

    a_bvalid_write: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid |-> state == st_busy && cur_cmd.wr && wdata_sent && b.id == txn_id)
        else $error("write response before the burst completed");

endmodule

//--- cache_axi_bridge.f
+incdir+.
cache_req_pkg.sv
axi_bus_pkg.sv
miss_arbiter.sv
burst_issuer.sv
axi_chan_slice.sv
cache_axi_bridge_top.sv
tb_axi_mem_model.sv
tb_cache_axi_bridge.sv

//--- cache_axi_bridge_top.sv
`timescale 1ns/1ps
`include "cache_axi_consts.svh"

module cache_axi_bridge_top (
    input  logic                        clk,
    input  logic                        rst_n,
    // instruction cache
    input  logic                        inst_rd_req,
    input  logic [`CA_ADDR_W-1:0]       inst_rd_addr,
    output logic                        inst_rd_rdy,
    output cache_req_pkg::cache_ret_t   inst_ret,
    // data cache
    input  logic                        data_rd_req,
    input  logic [`CA_ADDR_W-1:0]       data_rd_addr,
    output logic                        data_rd_rdy,
    input  logic                        data_wr_req,
    input  logic [`CA_ADDR_W-1:0]       data_wr_addr,
    input  logic [`CA_BEAT_W/8-1:0]     data_wr_wstrb,
    input  logic [`CA_LINE_W-1:0]       data_wr_data,
    output logic                        data_wr_rdy,
    output cache_req_pkg::cache_ret_t   data_ret,
    // axi3 master
    output axi_bus_pkg::axi_ar_t        ar,
    output logic                        arvalid,
    input  logic                        arready,
    output axi_bus_pkg::axi_ar_t        aw,
    output logic                        awvalid,
    input  logic                        awready,
    output axi_bus_pkg::axi_w_t         w,
    output logic                        wvalid,
    input  logic                        wready,
    input  axi_bus_pkg::axi_r_t         r,
    input  logic                        rvalid,
    output logic                        rready,
    input  axi_bus_pkg::axi_b_t         b,
    input  logic                        bvalid,
    output logic                        bready
);

    import cache_req_pkg::*;
    import axi_bus_pkg::*;

    bus_cmd_t   cmd;
    logic       cmd_valid;
    logic       cmd_ready;
    axi_ar_t    ar_in;
    logic       ar_in_valid;
    logic       ar_in_ready;
    axi_ar_t    aw_in;
    logic       aw_in_valid;
    logic       aw_in_ready;

    miss_arbiter u_arbiter (
        .clk, .rst_n,
        .inst_rd_req, .inst_rd_addr, .inst_rd_rdy,
        .data_rd_req, .data_rd_addr, .data_rd_rdy,
        .data_wr_req, .data_wr_addr, .data_wr_wstrb, .data_wr_data, .data_wr_rdy,
        .cmd, .cmd_valid, .cmd_ready
    );

    burst_issuer u_issuer (
        .clk, .rst_n,
        .cmd, .cmd_valid, .cmd_ready,
        .ar_in, .ar_in_valid, .ar_in_ready,
        .aw_in, .aw_in_valid, .aw_in_ready,
        .w, .wvalid, .wready,
        .r, .rvalid, .rready,
        .b, .bvalid, .bready,
        .inst_ret, .data_ret
    );

    axi_chan_slice #(.payload_t(axi_ar_t)) u_ar_slice (
        .clk, .rst_n,
        .in_data(ar_in), .in_valid(ar_in_valid), .in_ready(ar_in_ready),
        .out_data(ar), .out_valid(arvalid), .out_ready(arready)
    );

    axi_chan_slice #(.payload_t(axi_ar_t)) u_aw_slice (
        .clk, .rst_n,
        .in_data(aw_in), .in_valid(aw_in_valid), .in_ready(aw_in_ready),
        .out_data(aw), .out_valid(awvalid), .out_ready(awready)
    );

endmodule

//--- cache_axi_consts.svh
`ifndef CACHE_AXI_CONSTS_SVH
`define CACHE_AXI_CONSTS_SVH

// byte address width on both the cache side and the AXI side
`define CA_ADDR_W 32

// one AXI data beat
`define CA_BEAT_W 32

// beats in every burst, fixed by the line size
`define CA_BURST_BEATS 4

// full cache line, carried whole for a write miss
`define CA_LINE_W 128

// only the low bit carries the requester
`define CA_AXI_ID_W 4

`endif

//--- cache_req_pkg.sv
`include "cache_axi_consts.svh"

package cache_req_pkg;

    // which cache a command belongs to, doubles as axi id bit 0
    typedef enum logic {
        src_icache = 1'b0,
        src_dcache = 1'b1
    } cache_src_e;

    // one stored miss, read or write
    typedef struct packed {
        cache_src_e                 src;
        logic                       wr;     // 1 = write burst
        logic [`CA_ADDR_W-1:0]      addr;
        logic [`CA_BEAT_W/8-1:0]    wstrb;  // same strobe on all beats
        logic [`CA_LINE_W-1:0]      line;   // beat k at bits 32k +: 32
    } bus_cmd_t;

    // read beat handed back to a cache, no back-pressure
    typedef struct packed {
        logic                       valid;
        logic                       last;
        logic [`CA_BEAT_W-1:0]      data;
    } cache_ret_t;

endpackage

//--- miss_arbiter.sv
`timescale 1ns/1ps
`include "cache_axi_consts.svh"

module miss_arbiter (
    input  logic                        clk,
    input  logic                        rst_n,
    // instruction cache, reads only
    input  logic                        inst_rd_req,
    input  logic [`CA_ADDR_W-1:0]       inst_rd_addr,
    output logic                        inst_rd_rdy,
    // data cache
    input  logic                        data_rd_req,
    input  logic [`CA_ADDR_W-1:0]       data_rd_addr,
    output logic                        data_rd_rdy,
    input  logic                        data_wr_req,
    input  logic [`CA_ADDR_W-1:0]       data_wr_addr,
    input  logic [`CA_BEAT_W/8-1:0]     data_wr_wstrb,
    input  logic [`CA_LINE_W-1:0]       data_wr_data,
    output logic                        data_wr_rdy,
    // towards the issuer
    output cache_req_pkg::bus_cmd_t     cmd,
    output logic                        cmd_valid,
    input  logic                        cmd_ready
);

    import cache_req_pkg::*;

    logic       data_req;
    logic       data_gnt;
    logic       inst_gnt;
    bus_cmd_t   req_cmd;

    assign data_req = data_rd_req || data_wr_req; // never both at once

    // reads only wait for a free slot
    assign data_rd_rdy = !cmd_valid;
    // a write also waits for the issuer to drain, so rdy rising marks write done
    assign data_wr_rdy = !cmd_valid && cmd_ready;
    assign inst_rd_rdy = !cmd_valid && !data_req;   // dcache has priority

    assign data_gnt = (data_rd_req && data_rd_rdy) || (data_wr_req && data_wr_rdy);
    assign inst_gnt = inst_rd_req && inst_rd_rdy;

    // pack the winning request
    always_comb begin
        req_cmd = '0;   // strobe and line stay zero for reads
        if (data_wr_req) begin
            req_cmd.src   = src_dcache;
            req_cmd.wr    = 1'b1;
            req_cmd.addr  = data_wr_addr;
            req_cmd.wstrb = data_wr_wstrb;
            req_cmd.line  = data_wr_data;
        end else if (data_rd_req) begin
            req_cmd.src   = src_dcache;
            req_cmd.addr  = data_rd_addr;
        end else begin
            req_cmd.src   = src_icache;
            req_cmd.addr  = inst_rd_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_valid <= 1'b0;
        end else if (data_gnt || inst_gnt) begin
            cmd_valid <= 1'b1;
        end else if (cmd_ready) begin
            cmd_valid <= 1'b0;  // issuer took it
        end
    end

    always_ff @(posedge clk) begin
        if (data_gnt || inst_gnt) begin
            cmd <= req_cmd;
        end
    end

    // one winner per cycle
    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_gnt && inst_gnt))
        else $error("both caches granted in one cycle");

endmodule

//--- tb_axi_mem_model.sv
`timescale 1ns/1ps
`include "cache_axi_consts.svh"

module tb_axi_mem_model (
    input  logic                    clk,
    input  logic                    rst_n,
    input  axi_bus_pkg::axi_ar_t    ar,
    input  logic                    arvalid,
    output logic                    arready,
    input  axi_bus_pkg::axi_ar_t    aw,
    input  logic                    awvalid,
    output logic                    awready,
    input  axi_bus_pkg::axi_w_t     w,
    input  logic                    wvalid,
    output logic                    wready,
    output axi_bus_pkg::axi_r_t     r,
    output logic                    rvalid,
    input  logic                    rready,
    output axi_bus_pkg::axi_b_t     b,
    output logic                    bvalid,
    input  logic                    bready
);

    import axi_bus_pkg::*;

    logic [31:0]                mem [0:255];
    logic [31:0]                w_data [0:3];   // beats may arrive before aw
    logic [3:0]                 w_strb;
    logic [31:0]                rng;
    logic [7:0]                 rd_idx;
    logic [7:0]                 wr_idx;
    logic [1:0]                 rd_cnt;
    logic [1:0]                 w_cnt;
    logic                       rd_busy;
    logic                       aw_got;
    logic                       w_full;
    logic [`CA_AXI_ID_W-1:0]    rd_id;
    logic [`CA_AXI_ID_W-1:0]    wr_id;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= i * 32'h01010101;     // fill depends on the word address
            end
            rng     <= 32'h1ded30ab;
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= 1'b0;
            bvalid  <= 1'b0;
            r       <= '0;
            b       <= '0;
            rd_busy <= 1'b0;
            aw_got  <= 1'b0;
            w_full  <= 1'b0;
            w_cnt   <= '0;
        end else begin
            rng     <= lcg_step(rng);
            arready <= rng[31:30] != 2'b00;     // roughly one stall in four
            awready <= rng[29:28] != 2'b00;
            wready  <= rng[27:26] != 2'b00;

            // read burst with beats back to back
            if (arvalid && arready) begin
                rd_busy <= 1'b1;
                rd_idx  <= ar.addr[9:2];
                rd_id   <= ar.id;
                rd_cnt  <= '0;
            end
            if (rready) begin
                rvalid <= 1'b0;
            end
            if (rd_busy && (!rvalid || rready)) begin
                rvalid <= 1'b1;
                r.id   <= rd_id;
                r.data <= mem[rd_idx];
                r.resp <= 2'b00;
                r.last <= (rd_cnt == 2'd3);
                rd_idx <= rd_idx + 8'd1;
                rd_cnt <= rd_cnt + 2'd1;
                if (rd_cnt == 2'd3) begin
                    rd_busy <= 1'b0;
                end
            end

            // write burst is committed once both address and data are in
            if (awvalid && awready) begin
                aw_got <= 1'b1;
                wr_idx <= aw.addr[9:2];
                wr_id  <= aw.id;
            end
            if (wvalid && wready && !w_full) begin
                w_data[w_cnt] <= w.data;
                w_strb        <= w.strb;
                w_cnt         <= w_cnt + 2'd1;
                w_full        <= w.last;
            end
            if (bready) begin
                bvalid <= 1'b0;
            end
            if (aw_got && w_full) begin
                for (int k = 0; k < 4; k++) begin
                    for (int j = 0; j < 4; j++) begin
                        if (w_strb[j]) begin
                            mem[wr_idx + 8'(k)][8*j +: 8] <= w_data[k][8*j +: 8];
                        end
                    end
                end
                bvalid <= 1'b1;
                b.id   <= wr_id;
                b.resp <= 2'b00;
                aw_got <= 1'b0;
                w_full <= 1'b0;
                w_cnt  <= '0;
            end
        end
    end

endmodule

//--- tb_cache_axi_bridge.sv
`timescale 1ns/1ps
`include "cache_axi_consts.svh"

module tb_cache_axi_bridge;

    import cache_req_pkg::*;
    import axi_bus_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int NUM_TXN      = 40;
    localparam int TXN_CYCLES   = 40;
    localparam int MAX_CYCLES   = NUM_TXN * TXN_CYCLES + RESET_CYCLES;

    // four beats of four bytes, incrementing, word aligned
    localparam logic [14:0] ADDR_FIXED = {8'd3, 3'd2, 2'b01, 2'b00};

    logic                       clk;
    logic                       rst_n;
    logic                       inst_rd_req;
    logic [`CA_ADDR_W-1:0]      inst_rd_addr;
    logic                       inst_rd_rdy;
    logic                       data_rd_req;
    logic [`CA_ADDR_W-1:0]      data_rd_addr;
    logic                       data_rd_rdy;
    logic                       data_wr_req;
    logic [`CA_ADDR_W-1:0]      data_wr_addr;
    logic [`CA_BEAT_W/8-1:0]    data_wr_wstrb;
    logic [`CA_LINE_W-1:0]      data_wr_data;
    logic                       data_wr_rdy;
    cache_ret_t                 inst_ret;
    cache_ret_t                 data_ret;
    axi_ar_t                    ar;
    axi_ar_t                    aw;
    axi_w_t                     w;
    axi_r_t                     r;
    axi_b_t                     b;
    logic                       arvalid;
    logic                       arready;
    logic                       awvalid;
    logic                       awready;
    logic                       wvalid;
    logic                       wready;
    logic                       rvalid;
    logic                       rready;
    logic                       bvalid;
    logic                       bready;

    // expected {last, data} beats in one ring per source (0 icache and 1 dcache)
    logic [32:0]                exp_beats [2][16];
    int                         push_cnt [2];
    int                         pop_cnt [2] = '{0, 0};
    logic [32:0]                inst_head;
    logic [32:0]                data_head;
    logic [31:0]                ref_mem [0:255];
    int                         value_errs = 0;
    int                         proto_errs = 0;
    int                         cycle_cnt = 0;

    cache_axi_bridge_top UUT (.*);

    tb_axi_mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    assign inst_head = exp_beats[0][pop_cnt[0] % 16];
    assign data_head = exp_beats[1][pop_cnt[1] % 16];

    always @(posedge clk) begin
        if (inst_ret.valid && push_cnt[0] != pop_cnt[0]) begin
            pop_cnt[0] <= pop_cnt[0] + 1;
        end
        if (data_ret.valid && push_cnt[1] != pop_cnt[1]) begin
            pop_cnt[1] <= pop_cnt[1] + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, a miss was never answered", cycle_cnt);
            $display("TEST FAIL");
            $finish;
        end
    end

    a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |->
        !arvalid && !awvalid && !wvalid && !inst_ret.valid && !data_ret.valid &&
        inst_rd_rdy && data_rd_rdy && data_wr_rdy)
        else begin
            proto_errs++;
            $display("after reset a valid output was high or a rdy output was low");
        end

    a_inst_owner: assert property (@(posedge clk) disable iff (!rst_n)
        inst_ret.valid |-> push_cnt[0] != pop_cnt[0])
        else begin
            proto_errs++;
            $display("inst_ret beat with no instruction read outstanding");
        end

    a_inst_beat: assert property (@(posedge clk) disable iff (!rst_n)
        inst_ret.valid && push_cnt[0] != pop_cnt[0] |->
        {inst_ret.last, inst_ret.data} == inst_head)
        else begin
            value_errs++;
            $display("ERROR inst_ret {last,data} got %h expected %h",
                     $sampled({inst_ret.last, inst_ret.data}), $sampled(inst_head));
        end

    a_data_owner: assert property (@(posedge clk) disable iff (!rst_n)
        data_ret.valid |-> push_cnt[1] != pop_cnt[1])
        else begin
            proto_errs++;
            $display("data_ret beat with no data read outstanding");
        end

    a_data_beat: assert property (@(posedge clk) disable iff (!rst_n)
        data_ret.valid && push_cnt[1] != pop_cnt[1] |->
        {data_ret.last, data_ret.data} == data_head)
        else begin
            value_errs++;
            $display("ERROR data_ret {last,data} got %h expected %h",
                     $sampled({data_ret.last, data_ret.data}), $sampled(data_head));
        end

    a_dcache_first: assert property (@(posedge clk) disable iff (!rst_n)
        inst_rd_req && (data_rd_req || data_wr_req) |-> !inst_rd_rdy)
        else begin
            proto_errs++;
            $display("instruction read offered a grant while the data cache requested");
        end

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            proto_errs++;
            $display("AR payload or valid changed while arready was low");
        end

    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(aw))
        else begin
            proto_errs++;
            $display("AW payload or valid changed while awready was low");
        end

    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(w))
        else begin
            proto_errs++;
            $display("W payload or valid changed while wready was low");
        end

    a_ar_fields: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid |-> {ar.len, ar.size, ar.burst, ar.addr[1:0]} == ADDR_FIXED)
        else begin
            value_errs++;
            $display("ERROR ar {len,size,burst,addr[1:0]} got %h expected %h",
                     $sampled({ar.len, ar.size, ar.burst, ar.addr[1:0]}), ADDR_FIXED);
        end

    // only the data cache writes
    a_aw_fields: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid |-> {aw.id, aw.len, aw.size, aw.burst, aw.addr[1:0]} == {4'h1, ADDR_FIXED})
        else begin
            value_errs++;
            $display("ERROR aw {id,len,size,burst,addr[1:0]} got %h expected %h",
                     $sampled({aw.id, aw.len, aw.size, aw.burst, aw.addr[1:0]}),
                     {4'h1, ADDR_FIXED});
        end

    a_w_id: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid |-> w.id == 4'h1)
        else begin
            value_errs++;
            $display("ERROR w.id got %h expected %h", $sampled(w.id), 4'h1);
        end

    a_resp_ready: assert property (@(posedge clk) disable iff (!rst_n)
        rready && bready)
        else begin
            proto_errs++;
            $display("rready or bready went low although responses are always taken");
        end

    // kind 0 is an icache read, 1 a dcache read and 2 a dcache write
    // returns once the request is accepted
    task automatic issue_miss(input int kind, input logic [31:0] addr,
                              input logic [3:0] strb, input logic [127:0] line);
        logic [7:0] idx;
        @(negedge clk);
        case (kind)
            0: begin
                inst_rd_req  = 1'b1;
                inst_rd_addr = addr;
            end
            1: begin
                data_rd_req  = 1'b1;
                data_rd_addr = addr;
            end
            default: begin
                data_wr_req   = 1'b1;
                data_wr_addr  = addr;
                data_wr_wstrb = strb;
                data_wr_data  = line;
            end
        endcase
        #1;
        while (!(kind == 0 ? inst_rd_rdy : (kind == 1 ? data_rd_rdy : data_wr_rdy))) begin
            @(negedge clk);
            #1;
        end
        idx = addr[9:2];    // low address bits are dropped by the bridge
        for (int k = 0; k < 4; k++) begin
            if (kind == 2) begin
                for (int j = 0; j < 4; j++) begin
                    if (strb[j]) begin
                        ref_mem[idx][8*j +: 8] = line[32*k + 8*j +: 8];
                    end
                end
            end else begin
                exp_beats[kind][push_cnt[kind] % 16] = {k == 3, ref_mem[idx]};
                push_cnt[kind]++;
            end
            idx++;
        end
        @(negedge clk);     // handshake edge has passed
        case (kind)
            0: inst_rd_req = 1'b0;
            1: data_rd_req = 1'b0;
            default: data_wr_req = 1'b0;
        endcase
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] addr;
        rst_n         = 1'b0;
        inst_rd_req   = 1'b0;
        inst_rd_addr  = '0;
        data_rd_req   = 1'b0;
        data_rd_addr  = '0;
        data_wr_req   = 1'b0;
        data_wr_addr  = '0;
        data_wr_wstrb = '0;
        data_wr_data  = '0;
        push_cnt      = '{0, 0};
        rnd           = 32'h1ded30ab;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = i * 32'h01010101;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        issue_miss(0, 32'h0000_0040, '0, '0);
        issue_miss(0, 32'h0000_0ffe, '0, '0);   // unaligned start that wraps the model
        // partial strobes merge with the old contents
        issue_miss(2, 32'h0000_0080, 4'b0101, 128'h44444444_33333333_22222222_11111111);
        issue_miss(1, 32'h0000_0080, '0, '0);
        issue_miss(2, 32'h0000_03fc, 4'b1110, 128'hdeadbeef_cafef00d_0badc0de_feedface);
        issue_miss(1, 32'h0000_03fc, '0, '0);

        // both caches in the same cycle
        fork
            issue_miss(0, 32'h0000_0100, '0, '0);
            issue_miss(1, 32'h0000_0200, '0, '0);
        join
        fork
            issue_miss(0, 32'h0000_0300, '0, '0);
            issue_miss(2, 32'h0000_0300, 4'b1111, 128'h0f0f0f0f_f0f0f0f0_a5a5a5a5_5a5a5a5a);
        join

        for (int n = 0; n < 28; n++) begin
            rnd  = lcg_next(rnd);
            addr = rnd;
            rnd  = lcg_next(rnd);
            issue_miss(rnd[31:30] % 3, addr, rnd[7:4], {rnd, ~rnd, addr, addr ^ rnd});
        end

        // every beat back and the last write acknowledged
        while (push_cnt[0] != pop_cnt[0] || push_cnt[1] != pop_cnt[1] || !data_wr_rdy) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        $display("checks done: %0d value errors, %0d protocol errors", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
